/* design/vcop_pkg.sv */
`default_nettype none

package vcop_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int ELEN      = 32;                 // Fixed SEW
    localparam int NUM_LANES = 4;                  // Elements per register, ALU lanes
    localparam int VLEN      = ELEN * NUM_LANES;
    localparam int NUM_VREGS = 32;
    localparam int VREG_AW   = 5;
    localparam int APB_AW    = 12;

    // Register map
    localparam logic [APB_AW-1:0] ADDR_INSTR  = 12'h000;  // Issue on write
    localparam logic [APB_AW-1:0] ADDR_SCALAR = 12'h004;
    localparam logic [APB_AW-1:0] ADDR_VWIN   = 12'h400;  // Bits 8:4 reg, 3:2 element

    //////////////////////////////////////////////////
    // RVV encodings
    //////////////////////////////////////////////////
    localparam logic [6:0] OPC_OPV = 7'b1010111;

    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPMVV = 3'b010;
    localparam logic [2:0] F3_OPIVI = 3'b011;
    localparam logic [2:0] F3_OPIVX = 3'b100;

    localparam logic [5:0] F6_VADD    = 6'b000000;
    localparam logic [5:0] F6_VSUB    = 6'b000010;
    localparam logic [5:0] F6_VAND    = 6'b001001;
    localparam logic [5:0] F6_VOR     = 6'b001010;
    localparam logic [5:0] F6_VXOR    = 6'b001011;
    localparam logic [5:0] F6_VREDSUM = 6'b000000;  // Under OPMVV only

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;
    typedef enum logic [1:0] {SRC_VS1, SRC_SCALAR, SRC_IMM} src_sel_e;

    typedef logic [ELEN-1:0] elem_t;
    typedef elem_t [NUM_LANES-1:0] vreg_t;   // Element 0 in the low bits

    typedef struct packed {
        logic               is_red;   // vredsum, else element-wise
        alu_op_e            alu_op;
        src_sel_e           src_sel;
        logic [VREG_AW-1:0] vd;
        logic [VREG_AW-1:0] vs1;
        logic [VREG_AW-1:0] vs2;
        logic [4:0]         imm5;
    } dec_instr_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic               en;
        logic [VREG_AW-1:0] addr;
        vreg_t              data;
    } vreg_wr_t;

    typedef struct packed {
        logic               en;
        logic [VREG_AW-1:0] addr;
        logic [1:0]         idx;
        elem_t              data;
    } elem_wr_t;

endpackage

`default_nettype wire

/* design/vcop_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module vcop_decoder (
    input  logic [31:0]          instr,
    output vcop_pkg::dec_instr_t dec,
    output logic                 illegal
);
    import vcop_pkg::*;

    logic [5:0] funct6;
    logic [2:0] funct3;
    logic       legal_op;   // funct6 and funct3 pair is implemented

    assign funct6 = instr[31:26];
    assign funct3 = instr[14:12];

    always_comb begin
        dec.is_red  = 1'b0;
        dec.alu_op  = ALU_ADD;
        dec.src_sel = SRC_VS1;
        dec.vd      = instr[11:7];
        dec.vs1     = instr[19:15];
        dec.vs2     = instr[24:20];
        dec.imm5    = instr[19:15];   // Same field as vs1 in the .vi form
        legal_op    = 1'b1;
        case (funct3)
            F3_OPIVV, F3_OPIVX, F3_OPIVI: begin
                case (funct6)
                    F6_VADD: dec.alu_op = ALU_ADD;
                    F6_VSUB: begin
                        dec.alu_op = ALU_SUB;
                        legal_op   = (funct3 != F3_OPIVI);   // No vsub.vi in RVV
                    end
                    F6_VAND: dec.alu_op = ALU_AND;
                    F6_VOR:  dec.alu_op = ALU_OR;
                    F6_VXOR: dec.alu_op = ALU_XOR;
                    default: legal_op = 1'b0;
                endcase
                if (funct3 == F3_OPIVX) begin
                    dec.src_sel = SRC_SCALAR;
                end else if (funct3 == F3_OPIVI) begin
                    dec.src_sel = SRC_IMM;
                end
            end
            F3_OPMVV: begin
                dec.is_red = 1'b1;                    // vs1[0] seeds the sum
                legal_op   = (funct6 == F6_VREDSUM);
            end
            default: legal_op = 1'b0;
        endcase
    end

    // Wrong major opcode, masked form (vm clear) or unknown pair
    assign illegal = (instr[6:0] != OPC_OPV) || !instr[25] || !legal_op;

endmodule

`default_nettype wire

/* design/vcop_apb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module vcop_apb_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  vcop_pkg::apb_req_t           apb_req,
    output vcop_pkg::apb_rsp_t           apb_rsp,
    output logic                         issue,
    output vcop_pkg::dec_instr_t         dec,
    output vcop_pkg::elem_t              scalar,
    input  logic                         done,
    output vcop_pkg::elem_wr_t           elem_wr,
    output logic [vcop_pkg::VREG_AW-1:0] elem_rd_addr,
    output logic [1:0]                   elem_rd_idx,
    input  vcop_pkg::elem_t              elem_rd_data
);
    import vcop_pkg::*;

    logic        access;       // APB access phase
    logic        sel_instr;
    logic        sel_scalar;
    logic        sel_win;
    logic        instr_wr;
    logic        pending;      // Instruction in flight
    logic [31:0] last_instr;
    dec_instr_t  dec_w;
    logic        illegal;

    vcop_decoder i_vcop_decoder (
        .instr   (apb_req.pwdata),
        .dec     (dec_w),
        .illegal (illegal)
    );

    assign access     = apb_req.psel && apb_req.penable;
    assign sel_instr  = (apb_req.paddr == ADDR_INSTR);
    assign sel_scalar = (apb_req.paddr == ADDR_SCALAR);
    assign sel_win    = (apb_req.paddr[APB_AW-1:9] == ADDR_VWIN[APB_AW-1:9]);
    assign instr_wr   = access && apb_req.pwrite && sel_instr;
    assign issue      = instr_wr && !illegal && !pending;   // Once per legal write

    // Element window straight onto the regfile ports
    assign elem_rd_addr = apb_req.paddr[8:4];
    assign elem_rd_idx  = apb_req.paddr[3:2];
    assign elem_wr.en   = access && apb_req.pwrite && sel_win;
    assign elem_wr.addr = apb_req.paddr[8:4];
    assign elem_wr.idx  = apb_req.paddr[3:2];
    assign elem_wr.data = apb_req.pwdata;

    // Unmapped reads return zero
    assign apb_rsp.prdata = sel_instr  ? last_instr   :
                            sel_scalar ? scalar       :
                            sel_win    ? elem_rd_data : '0;

    // Legal instruction writes stall until the writeback of vd
    assign apb_rsp.pready  = access && !(instr_wr && !illegal && !done);
    assign apb_rsp.pslverr = instr_wr && illegal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            last_instr <= '0;
            dec        <= '0;
            scalar     <= '0;
        end else begin
            if (issue) begin
                pending    <= 1'b1;
                last_instr <= apb_req.pwdata;
                dec        <= dec_w;      // Held for the whole execution
            end else if (done) begin
                pending <= 1'b0;
            end
            if (access && apb_req.pwrite && sel_scalar) begin
                scalar <= apb_req.pwdata;
            end
        end
    end

    // Only the stalled instruction write may be on the bus while busy
    a_held_transfer : assert property (@(posedge clk) disable iff (!rst_n)
        pending && apb_req.psel |->
            apb_req.pwrite && sel_instr && (apb_req.pwdata == last_instr));

endmodule

`default_nettype wire

/* design/vcop_vregfile.sv */
`timescale 1ns/10ps
`default_nettype none

module vcop_vregfile (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [vcop_pkg::VREG_AW-1:0] rd_addr_a,
    input  logic [vcop_pkg::VREG_AW-1:0] rd_addr_b,
    output vcop_pkg::vreg_t              rd_data_a,
    output vcop_pkg::vreg_t              rd_data_b,
    input  logic [vcop_pkg::VREG_AW-1:0] el_rd_addr,
    input  logic [1:0]                   el_rd_idx,
    output vcop_pkg::elem_t              el_rd_data,
    input  vcop_pkg::vreg_wr_t           vwr,
    input  vcop_pkg::elem_wr_t           ewr
);
    import vcop_pkg::*;

    vreg_t regs [NUM_VREGS];

    // Asynchronous reads
    assign rd_data_a  = regs[rd_addr_a];    // vs1 side
    assign rd_data_b  = regs[rd_addr_b];    // vs2 side
    assign el_rd_data = regs[el_rd_addr][el_rd_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (vwr.en) begin
            regs[vwr.addr] <= vwr.data;                 // Writeback of vd
        end else if (ewr.en) begin
            regs[ewr.addr][ewr.idx] <= ewr.data;        // Host window
        end
    end

    // Host window and writeback never overlap
    a_one_writer : assert property (@(posedge clk) disable iff (!rst_n)
        !(vwr.en && ewr.en));

endmodule

`default_nettype wire

/* design/vcop_valu.sv */
`timescale 1ns/10ps
`default_nettype none

module vcop_valu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  vcop_pkg::alu_op_e op,
    input  vcop_pkg::vreg_t   src_a,    // Source 1
    input  vcop_pkg::vreg_t   src_b,    // vs2
    output vcop_pkg::vreg_t   result
);
    import vcop_pkg::*;

    vreg_t lane_res;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            case (op)
                ALU_SUB: lane_res[l] = src_b[l] - src_a[l];   // vs2 minus source 1
                ALU_AND: lane_res[l] = src_b[l] & src_a[l];
                ALU_OR:  lane_res[l] = src_b[l] | src_a[l];
                ALU_XOR: lane_res[l] = src_b[l] ^ src_a[l];
                default: lane_res[l] = src_b[l] + src_a[l];   // Wraps mod 2^32
            endcase
        end
    end

    // Result valid the cycle after start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (start) begin
            result <= lane_res;
        end
    end

endmodule

`default_nettype wire

/* design/vcop_vred.sv */
`timescale 1ns/10ps
`default_nettype none

module vcop_vred (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  vcop_pkg::elem_t init,    // vs1[0]
    input  vcop_pkg::vreg_t src,     // vs2, held by the sequencer
    output logic            valid,
    output vcop_pkg::elem_t sum
);
    import vcop_pkg::*;

    logic       busy;
    logic [1:0] lane;    // Element being added
    elem_t      acc;

    assign sum = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            lane  <= '0;
            acc   <= '0;
            valid <= 1'b0;
        end else begin
            valid <= busy && (lane == 2'(NUM_LANES - 1));   // One-cycle pulse
            if (start) begin
                busy <= 1'b1;
                lane <= '0;
                acc  <= init;
            end else if (busy) begin
                acc  <= acc + src[lane];
                lane <= lane + 2'd1;
                if (lane == 2'(NUM_LANES - 1)) begin
                    busy <= 1'b0;    // Last element
                end
            end
        end
    end

    // Sequencer waits for valid before the next reduction
    a_no_restart : assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

`default_nettype wire

/* design/vcop_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module vcop_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         issue,
    input  vcop_pkg::dec_instr_t         dec,
    input  vcop_pkg::elem_t              scalar,
    output logic [vcop_pkg::VREG_AW-1:0] rd_addr_a,
    output logic [vcop_pkg::VREG_AW-1:0] rd_addr_b,
    input  vcop_pkg::vreg_t              rd_data_a,
    input  vcop_pkg::vreg_t              rd_data_b,
    output logic                         valu_start,
    output vcop_pkg::alu_op_e            valu_op,
    output vcop_pkg::vreg_t              valu_a,
    output vcop_pkg::vreg_t              valu_b,
    input  vcop_pkg::vreg_t              valu_result,
    output logic                         vred_start,
    output vcop_pkg::elem_t              vred_init,
    output vcop_pkg::vreg_t              vred_src,
    input  logic                         vred_valid,
    input  vcop_pkg::elem_t              vred_sum,
    output vcop_pkg::vreg_wr_t           vwr,
    output logic                         done
);
    import vcop_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_EXEC, S_WAIT} state_e;

    state_e state;
    vreg_t  src1;
    elem_t  imm_ext;

    // dec is registered at issue so both addresses stay put
    assign rd_addr_a = dec.vs1;
    assign rd_addr_b = dec.vs2;
    assign imm_ext   = {{(ELEN-5){1'b0}}, dec.imm5};   // Zero-extended

    //////////////////////////////////////////////////
    // Operand select and unit start
    //////////////////////////////////////////////////
    always_comb begin
        case (dec.src_sel)
            SRC_SCALAR: src1 = {NUM_LANES{scalar}};    // Broadcast
            SRC_IMM:    src1 = {NUM_LANES{imm_ext}};
            default:    src1 = rd_data_a;
        endcase
    end

    assign valu_start = (state == S_EXEC) && !dec.is_red;
    assign valu_op    = dec.alu_op;
    assign valu_a     = src1;
    assign valu_b     = rd_data_b;
    assign vred_start = (state == S_EXEC) && dec.is_red;
    assign vred_init  = rd_data_a[0];
    assign vred_src   = rd_data_b;

    //////////////////////////////////////////////////
    // Writeback
    //////////////////////////////////////////////////
    assign done     = (state == S_WAIT) && (!dec.is_red || vred_valid);
    assign vwr.en   = done;
    assign vwr.addr = dec.vd;
    assign vwr.data = dec.is_red ? vreg_t'({{(VLEN-ELEN){1'b0}}, vred_sum})   // Tail zero
                                 : valu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (issue) state <= S_EXEC;
                S_EXEC:  state <= S_WAIT;              // Unit started this cycle
                S_WAIT:  if (done) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/vcop_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vcop_top (
    input  logic               clk,
    input  logic               rst_n,
    input  vcop_pkg::apb_req_t apb_req,
    output vcop_pkg::apb_rsp_t apb_rsp
);
    import vcop_pkg::*;

    // Host side
    logic               issue;
    logic               done;
    dec_instr_t         dec;
    elem_t              scalar;
    elem_wr_t           elem_wr;
    logic [VREG_AW-1:0] elem_rd_addr;
    logic [1:0]         elem_rd_idx;
    elem_t              elem_rd_data;

    // Execution side
    logic [VREG_AW-1:0] rd_addr_a;
    logic [VREG_AW-1:0] rd_addr_b;
    vreg_t              rd_data_a;
    vreg_t              rd_data_b;
    vreg_wr_t           vwr;
    logic               valu_start;
    alu_op_e            valu_op;
    vreg_t              valu_a;
    vreg_t              valu_b;
    vreg_t              valu_result;
    logic               vred_start;
    elem_t              vred_init;
    vreg_t              vred_src;
    logic               vred_valid;
    elem_t              vred_sum;

    vcop_apb_regs i_vcop_apb_regs (
        .clk, .rst_n, .apb_req, .apb_rsp, .issue, .dec, .scalar, .done,
        .elem_wr, .elem_rd_addr, .elem_rd_idx, .elem_rd_data
    );

    vcop_vregfile i_vcop_vregfile (
        .clk, .rst_n, .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .el_rd_addr (elem_rd_addr),
        .el_rd_idx  (elem_rd_idx),
        .el_rd_data (elem_rd_data),
        .vwr,
        .ewr        (elem_wr)
    );

    vcop_ctrl i_vcop_ctrl (
        .clk, .rst_n, .issue, .dec, .scalar, .rd_addr_a, .rd_addr_b,
        .rd_data_a, .rd_data_b, .valu_start, .valu_op, .valu_a, .valu_b,
        .valu_result, .vred_start, .vred_init, .vred_src, .vred_valid,
        .vred_sum, .vwr, .done
    );

    vcop_valu i_vcop_valu (
        .clk, .rst_n,
        .start  (valu_start),
        .op     (valu_op),
        .src_a  (valu_a),
        .src_b  (valu_b),
        .result (valu_result)
    );

    vcop_vred i_vcop_vred (
        .clk, .rst_n,
        .start (vred_start),
        .init  (vred_init),
        .src   (vred_src),
        .valid (vred_valid),
        .sum   (vred_sum)
    );

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;    // First rising edge at half a period
    end

    // Covers RESET_CYCLES rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        #(PERIOD_NS * RESET_CYCLES);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_vcop.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_vcop;
    import vcop_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int N_VV          = 40;   // .vv instructions
    localparam int N_VXI         = 30;   // .vx and .vi instructions
    localparam int N_RED         = 12;   // Reductions

    // APB transfers per test section, for the watchdog
    localparam int N_TRANSFERS = 130 + 258 + N_VV * 5 + N_VXI * 6 + N_RED * 5 + 134;
    localparam int TIMEOUT_CYCLES = N_TRANSFERS * 20 + 200;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // Reference state
    logic [31:0] model_regs [32][4];
    logic [31:0] model_scalar;
    logic [31:0] model_instr;            // Last accepted instruction

    // Handoff to the comparing process
    event        read_done;
    logic [31:0] cmp_act;
    logic [31:0] cmp_exp;
    string       cmp_what;
    int          n_reads   = 0;
    int          n_checked = 0;

    tb_clkgen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (3)
    ) i_tb_clkgen (
        .clk,
        .rst_n
    );

    vcop_top i_vcop_top (
        .clk,
        .rst_n,
        .apb_req,
        .apb_rsp
    );

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////
    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            stop_on_error();
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    // Returns 1 for a legal word; res holds vd with element i in bits 32*i+31:32*i
    function automatic logic model_vd(input logic [31:0] instr, output logic [127:0] res);
        logic [5:0]  f6;
        logic [2:0]  f3;
        logic [4:0]  vs2;
        logic [4:0]  vs1;
        logic [31:0] src1;
        logic [31:0] sum;
        logic        legal;
        f6    = instr[31:26];
        f3    = instr[14:12];
        vs2   = instr[24:20];
        vs1   = instr[19:15];
        res   = '0;
        legal = (instr[6:0] == 7'b1010111) && instr[25];    // OP-V, unmasked
        if (f3 == 3'b010) begin
            legal = legal && (f6 == 6'b000000);             // vredsum.vs only
            sum   = model_regs[vs1][0];
            for (int i = 0; i < 4; i++) begin
                sum = sum + model_regs[vs2][i];             // Wraps mod 2^32
            end
            res[31:0] = sum;                                // Tail stays zero
        end else if (f3 == 3'b000 || f3 == 3'b011 || f3 == 3'b100) begin
            for (int i = 0; i < 4; i++) begin
                case (f3)
                    3'b100:  src1 = model_scalar;
                    3'b011:  src1 = {27'b0, vs1};           // imm5, zero-extended
                    default: src1 = model_regs[vs1][i];
                endcase
                case (f6)
                    6'b000000: res[i*32 +: 32] = model_regs[vs2][i] + src1;
                    6'b000010: begin
                        res[i*32 +: 32] = model_regs[vs2][i] - src1;
                        legal = legal && (f3 != 3'b011);    // No vsub.vi
                    end
                    6'b001001: res[i*32 +: 32] = model_regs[vs2][i] & src1;
                    6'b001010: res[i*32 +: 32] = model_regs[vs2][i] | src1;
                    6'b001011: res[i*32 +: 32] = model_regs[vs2][i] ^ src1;
                    default:   legal = 1'b0;
                endcase
            end
        end else begin
            legal = 1'b0;
        end
        return legal;
    endfunction

    function automatic logic [31:0] encode_opv(input logic [5:0] f6, input logic [4:0] vs2,
                                               input logic [4:0] src, input logic [2:0] f3,
                                               input logic [4:0] vd);
        return {f6, 1'b1, vs2, src, f3, vd, 7'b1010111};
    endfunction

    // 0 add, 1 sub, 2 and, 3 or, 4 xor
    function automatic logic [5:0] funct6_of(input int k);
        case (k)
            0:       return 6'b000000;
            1:       return 6'b000010;
            2:       return 6'b001001;
            3:       return 6'b001010;
            default: return 6'b001011;
        endcase
    endfunction

    function automatic logic [11:0] win_addr(input int r, input int e);
        return ADDR_VWIN | 12'(r * 16) | 12'(e * 4);
    endfunction

    //////////////////////////////////////////////////
    // APB host
    //////////////////////////////////////////////////
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        logic finished;
        @(negedge clk);
        apb_req.psel    = 1'b1;          // Setup
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;          // Access
        finished = 1'b0;
        while (!finished) begin
            #1;                          // Mid-cycle, away from both edges
            if (apb_rsp.pready) begin
                rdata    = apb_rsp.prdata;
                err      = apb_rsp.pslverr;
                finished = 1'b1;
            end
            @(posedge clk);              // Transfer ends on this edge if pready
            if (!finished) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] rdata;
        apb_transfer(1'b1, addr, data, rdata, err);
    endtask

    // Read, then pass the value on to the comparing process
    task automatic read_expect(input logic [11:0] addr, input logic [31:0] expected,
                               input string what);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
        check_value({31'b0, err}, 32'h0, $sformatf("%s pslverr", what));
        cmp_act  = rdata;
        cmp_exp  = expected;
        cmp_what = what;
        n_reads++;
        -> read_done;
    endtask

    task automatic write_elem(input int r, input int e, input logic [31:0] data);
        logic err;
        apb_write(win_addr(r, e), data, err);
        check_value({31'b0, err}, 32'h0, "window write pslverr");
        model_regs[r][e] = data;
    endtask

    task automatic write_scalar(input logic [31:0] data);
        logic err;
        apb_write(ADDR_SCALAR, data, err);
        check_value({31'b0, err}, 32'h0, "scalar write pslverr");
        model_scalar = data;
    endtask

    task automatic check_vreg(input int r, input string what);
        for (int e = 0; e < 4; e++) begin
            read_expect(win_addr(r, e), model_regs[r][e],
                        $sformatf("%s v%0d[%0d]", what, r, e));
        end
    endtask

    // Issue one word; legal ones update the model and read vd back
    task automatic run_instr(input logic [31:0] instr, input string what);
        logic [127:0] expect_vd;
        logic         legal;
        logic         err;
        int           vd;
        legal = model_vd(instr, expect_vd);
        vd    = int'(instr[11:7]);
        apb_write(ADDR_INSTR, instr, err);
        check_value({31'b0, err}, {31'b0, !legal}, $sformatf("%s pslverr", what));
        if (legal) begin
            model_instr = instr;
            for (int e = 0; e < 4; e++) begin
                model_regs[vd][e] = expect_vd[e*32 +: 32];
            end
            check_vreg(vd, what);
        end
    endtask

    //////////////////////////////////////////////////
    // Comparing process and watchdog
    //////////////////////////////////////////////////
    initial begin
        forever begin
            @(read_done);
            check_value(cmp_act, cmp_exp, cmp_what);
            n_checked++;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_on_error();
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        logic [31:0] instr;
        logic [4:0]  vd;
        logic [4:0]  vs1;
        logic [4:0]  vs2;
        logic [4:0]  imm;
        int          k;
        void'($urandom(80595));
        apb_req      = '0;
        model_scalar = '0;
        model_instr  = '0;
        for (int r = 0; r < 32; r++) begin
            for (int e = 0; e < 4; e++) begin
                model_regs[r][e] = '0;
            end
        end
        wait (rst_n === 1'b1);

        // Everything reads zero out of reset
        for (int r = 0; r < 32; r++) begin
            check_vreg(r, "reset");
        end
        read_expect(ADDR_SCALAR, 32'h0, "reset scalar");
        read_expect(ADDR_INSTR, 32'h0, "reset instr");

        // Window and scalar round trip, also fills every register
        for (int r = 0; r < 32; r++) begin
            for (int e = 0; e < 4; e++) begin
                write_elem(r, e, $urandom());
            end
        end
        for (int r = 0; r < 32; r++) begin
            check_vreg(r, "window");
        end
        write_scalar($urandom());
        read_expect(ADDR_SCALAR, model_scalar, "scalar");

        // .vv, all five operations, with vd on a source now and then
        for (int n = 0; n < N_VV; n++) begin
            vd  = 5'($urandom_range(31));
            vs1 = 5'($urandom_range(31));
            vs2 = 5'($urandom_range(31));
            if (n % 4 == 1) begin
                vd = vs2;
            end else if (n % 4 == 2) begin
                vd = vs1;
            end
            k = n % 5;
            run_instr(encode_opv(funct6_of(k), vs2, vs1, 3'b000, vd),
                      $sformatf("vv op%0d", k));
        end

        // .vx and .vi, fresh scalar each time
        for (int n = 0; n < N_VXI; n++) begin
            write_scalar($urandom());
            vd  = 5'($urandom_range(31));
            vs2 = 5'($urandom_range(31));
            imm = 5'($urandom_range(31));
            if (n % 6 == 1) begin
                imm = 5'h1F;                          // Top bit set, no sign extension
            end
            if (n % 2 == 0) begin
                k = n % 5;
                run_instr(encode_opv(funct6_of(k), vs2, imm, 3'b100, vd),
                          $sformatf("vx op%0d", k));
            end else begin
                k = (n / 2) % 4;
                if (k == 1) begin
                    k = 4;                            // Skip sub in the .vi form
                end
                run_instr(encode_opv(funct6_of(k), vs2, imm, 3'b011, vd),
                          $sformatf("vi op%0d", k));
            end
        end

        // vredsum.vs over random data, sums wrap
        for (int n = 0; n < N_RED; n++) begin
            vd  = 5'($urandom_range(31));
            vs1 = 5'($urandom_range(31));
            vs2 = 5'($urandom_range(31));
            if (n % 3 == 1) begin
                vd = vs1;
            end else if (n % 3 == 2) begin
                vd = vs2;
            end
            run_instr(encode_opv(6'b000000, vs2, vs1, 3'b010, vd), "vredsum");
        end

        // Illegal words leave all state alone
        vd  = 5'($urandom_range(31));
        vs1 = 5'($urandom_range(31));
        vs2 = 5'($urandom_range(31));
        instr = encode_opv(6'b000000, vs2, vs1, 3'b000, vd);
        instr[25] = 1'b0;                             // Masked
        run_instr(instr, "masked vadd.vv");
        run_instr(encode_opv(6'b000010, vs2, vs1, 3'b011, vd), "vsub.vi");
        instr = encode_opv(6'b000000, vs2, vs1, 3'b000, vd);
        instr[6:0] = 7'b0110011;
        run_instr(instr, "wrong opcode");
        run_instr(encode_opv(6'b000100, vs2, vs1, 3'b000, vd), "unknown funct6");
        for (int r = 0; r < 32; r++) begin
            check_vreg(r, "after illegal");
        end
        read_expect(ADDR_SCALAR, model_scalar, "scalar after illegal");
        read_expect(ADDR_INSTR, model_instr, "last accepted instr");

        @(negedge clk);                               // Last comparison runs first
        if (n_checked != n_reads) begin
            $display("Only %0d of %0d reads reached the comparing process",
                     n_checked, n_reads);
            stop_on_error();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
design/vcop_pkg.sv
design/vcop_decoder.sv
design/vcop_apb_regs.sv
design/vcop_vregfile.sv
design/vcop_valu.sv
design/vcop_vred.sv
design/vcop_ctrl.sv
design/vcop_top.sv
tb/tb_clkgen.sv
tb/tb_vcop.sv

/* Bender.yml */
package:
  name: vcop

sources:
  - files:
      - design/vcop_pkg.sv
      - design/vcop_decoder.sv
      - design/vcop_apb_regs.sv
      - design/vcop_vregfile.sv
      - design/vcop_valu.sv
      - design/vcop_vred.sv
      - design/vcop_ctrl.sv
      - design/vcop_top.sv
  - target: simulation
    files:
      - tb/tb_clkgen.sv
      - tb/tb_vcop.sv
